// File: btn_channel/btn_channel.sv
`default_nettype none

module btn_channel (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               btn,
    input  logic               tick,
    btn_stat_if.channel        stat
);

    import debug_cfg_pkg::*;

    logic                    sync_ff1;
    logic                    sync_ff2;
    db_state_e               db_state;
    logic [SETTLE_WIDTH-1:0] settle_cnt;
    logic                    level;
    logic                    level_d;
    logic                    level_rise;
    cnt_t                    press_cnt;
    cnt_t                    hold_cnt;

    // Two-flop synchronizer for the raw button
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_ff1 <= 1'b0;
            sync_ff2 <= 1'b0;
        end else begin
            sync_ff1 <= btn;
            sync_ff2 <= sync_ff1;
        end
    end

    // Debouncer
    // Counts consecutive samples that differ from level
    // Level flips once the count has reached DEBOUNCE_CYCLES
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            db_state   <= DB_STABLE;
            settle_cnt <= '0;
            level      <= 1'b0;
        end else begin
            case (db_state)
                DB_STABLE: begin
                    if (sync_ff2 != level) begin
                        db_state   <= DB_SETTLING;
                        settle_cnt <= SETTLE_WIDTH'(1);
                    end
                end
                DB_SETTLING: begin
                    if (sync_ff2 == level) begin
                        // Glitch ended early, keep old level
                        db_state   <= DB_STABLE;
                        settle_cnt <= '0;
                    end else if (settle_cnt == SETTLE_WIDTH'(DEBOUNCE_CYCLES)) begin
                        db_state   <= DB_STABLE;
                        settle_cnt <= '0;
                        level      <= sync_ff2;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                default: begin
                    db_state   <= DB_STABLE;
                    settle_cnt <= '0;
                end
            endcase
        end
    end

    // Delayed level for edge detect
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            level_d <= 1'b0;
        end else begin
            level_d <= level;
        end
    end

    assign level_rise = level & ~level_d;

    // Press counter, bumps the cycle after level rises
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            press_cnt <= '0;
        end else if (stat.clear) begin
            press_cnt <= '0;
        end else if (level_rise) begin
            press_cnt <= press_cnt + cnt_t'(1);
        end
    end

    // Hold counter, one step per tick while held
    // clear has priority over both counters
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hold_cnt <= '0;
        end else if (stat.clear) begin
            hold_cnt <= '0;
        end else if (tick && level) begin
            hold_cnt <= hold_cnt + cnt_t'(1);
        end
    end

    // Status out to the register block
    assign stat.level      = level;
    assign stat.presses    = press_cnt;
    assign stat.hold_ticks = hold_cnt;

endmodule

`default_nettype wire

// File: common/btn_stat_if.sv
`default_nettype none

interface btn_stat_if;

    import debug_cfg_pkg::*;

    // Debounced button level
    logic level;
    // Rising edges of level seen so far
    cnt_t presses;
    // Slow ticks seen with level high
    cnt_t hold_ticks;
    // One-cycle clear of both counters
    logic clear;

    // Button side
    modport channel (
        output level,
        output presses,
        output hold_ticks,
        input  clear
    );

    // Register block side
    modport regs (
        input  level,
        input  presses,
        input  hold_ticks,
        output clear
    );

endinterface

`default_nettype wire

// File: common/debug_cfg_pkg.sv
`default_nettype none

package debug_cfg_pkg;

    // Number of button channels: left, right, jump
    localparam int CHAN_NUM = 3;

    // Press, hold and sequence counter width
    localparam int CNT_WIDTH = 16;

    // Counter types
    typedef logic [CNT_WIDTH-1:0] cnt_t;
    typedef logic signed [CNT_WIDTH-1:0] seq_t;

    // System clock cycles per slow tick
    localparam int TICK_DIV = 64;
    localparam int TICK_CNT_WIDTH = $clog2(TICK_DIV);

    // Differing samples needed before the debounced level flips
    localparam int DEBOUNCE_CYCLES = 8;
    // Settling counter has to reach DEBOUNCE_CYCLES itself
    localparam int SETTLE_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);

    // Debouncer FSM states
    typedef enum logic {
        DB_STABLE   = 1'b0,
        DB_SETTLING = 1'b1
    } db_state_e;

endpackage

`default_nettype wire

// File: common/debug_regs_pkg.sv
`default_nettype none

package debug_regs_pkg;

    // APB widths
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    // Register map, byte addresses
    typedef enum logic [APB_ADDR_WIDTH-1:0] {
        REG_TICK_COUNT = 8'h00,
        REG_STATUS     = 8'h04,
        REG_CTRL       = 8'h08,
        REG_HOLD0      = 8'h10,
        REG_PRESS0     = 8'h14,
        REG_HOLD1      = 8'h18,
        REG_PRESS1     = 8'h1C,
        REG_HOLD2      = 8'h20,
        REG_PRESS2     = 8'h24
    } reg_addr_e;

    // Field positions
    // STATUS: one debounced level bit per channel
    localparam int STATUS_LEVEL_LSB = 0;
    // CTRL: one clear bit per channel
    localparam int CTRL_CLR_LSB = 0;

endpackage

`default_nettype wire

// File: design/btn_debug_top.sv
`default_nettype none

module btn_debug_top (
    input  logic                                       sys_clk,
    input  logic                                       sys_rst_n,
    input  logic                                       left_btn,
    input  logic                                       right_btn,
    input  logic                                       jump_btn,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [debug_regs_pkg::APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [debug_regs_pkg::APB_DATA_WIDTH-1:0]  pwdata,
    output logic [debug_regs_pkg::APB_DATA_WIDTH-1:0]  prdata,
    output logic                                       pready,
    output logic                                       pslverr
);

    import debug_cfg_pkg::*;

    logic                tick;
    seq_t                seq;
    logic [CHAN_NUM-1:0] raw_btn;

    // Channel 0 is left, 1 right, 2 jump
    assign raw_btn = {jump_btn, right_btn, left_btn};

    // One status link per channel
    btn_stat_if stat_if [CHAN_NUM] ();

    // Slow tick and sequence value
    debug_tick_gen u_tick_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (tick),
        .seq       (seq)
    );

    // Identical button channels
    for (genvar g = 0; g < CHAN_NUM; g++) begin : g_chan
        btn_channel u_btn_channel (
            .sys_clk   (sys_clk),
            .sys_rst_n (sys_rst_n),
            .btn       (raw_btn[g]),
            .tick      (tick),
            .stat      (stat_if[g])
        );
    end

    // APB register block
    debug_apb_regs u_apb_regs (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .seq       (seq),
        .stat      (stat_if)
    );

endmodule

`default_nettype wire

// File: design/debug_apb_regs.sv
`default_nettype none

module debug_apb_regs (
    input  logic                                       sys_clk,
    input  logic                                       sys_rst_n,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [debug_regs_pkg::APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [debug_regs_pkg::APB_DATA_WIDTH-1:0]  pwdata,
    output logic [debug_regs_pkg::APB_DATA_WIDTH-1:0]  prdata,
    output logic                                       pready,
    output logic                                       pslverr,
    input  debug_cfg_pkg::seq_t                        seq,
    btn_stat_if.regs                                   stat [debug_cfg_pkg::CHAN_NUM]
);

    import debug_cfg_pkg::*;
    import debug_regs_pkg::*;

    logic [CHAN_NUM-1:0]       levels;
    cnt_t                      press_cnt [CHAN_NUM];
    cnt_t                      hold_cnt  [CHAN_NUM];
    logic [APB_DATA_WIDTH-1:0] rdata;
    logic                      addr_hit;
    logic                      is_ctrl;
    logic                      xfer_err;
    logic                      setup_phase;
    logic                      access_phase;
    logic                      ctrl_wr;

    // Zero-extend a counter to bus width
    function automatic logic [APB_DATA_WIDTH-1:0] zext(input cnt_t val);
        return {{(APB_DATA_WIDTH - CNT_WIDTH){1'b0}}, val};
    endfunction

    // Sign-extend the sequence value to bus width
    function automatic logic [APB_DATA_WIDTH-1:0] sext(input seq_t val);
        return {{(APB_DATA_WIDTH - CNT_WIDTH){val[CNT_WIDTH-1]}}, val};
    endfunction

    // APB phases
    assign setup_phase  = psel & ~penable;
    assign access_phase = psel & penable;

    // No wait states
    assign pready = 1'b1;

    // Address decode and read mux
    always_comb begin
        rdata    = '0;
        addr_hit = 1'b1;
        is_ctrl  = 1'b0;
        case (reg_addr_e'(paddr))
            REG_TICK_COUNT: rdata = sext(seq);
            REG_STATUS:     rdata[STATUS_LEVEL_LSB +: CHAN_NUM] = levels;
            REG_CTRL:       is_ctrl = 1'b1;
            REG_HOLD0:      rdata = zext(hold_cnt[0]);
            REG_PRESS0:     rdata = zext(press_cnt[0]);
            REG_HOLD1:      rdata = zext(hold_cnt[1]);
            REG_PRESS1:     rdata = zext(press_cnt[1]);
            REG_HOLD2:      rdata = zext(hold_cnt[2]);
            REG_PRESS2:     rdata = zext(press_cnt[2]);
            default:        addr_hit = 1'b0;
        endcase
    end

    // Error on unmapped address
    // CTRL only takes writes, everything else only reads
    assign xfer_err = ~addr_hit | (pwrite ^ is_ctrl);

    // Read data and error latched in setup, valid through access
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup_phase) begin
            prdata  <= (pwrite || xfer_err) ? '0 : rdata;
            pslverr <= xfer_err;
        end else if (!psel) begin
            // Idle bus, drop stale data
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

    // Good CTRL write in its access cycle
    assign ctrl_wr = access_phase & pwrite & is_ctrl & addr_hit;

    // Per-channel gather and clear pulses
    // Counters see clear during the access cycle and read 0 right after
    for (genvar i = 0; i < CHAN_NUM; i++) begin : g_stat
        assign levels[i]     = stat[i].level;
        assign press_cnt[i]  = stat[i].presses;
        assign hold_cnt[i]   = stat[i].hold_ticks;
        assign stat[i].clear = ctrl_wr & pwdata[CTRL_CLR_LSB + i];
    end

endmodule

`default_nettype wire

// File: design/debug_tick_gen.sv
`default_nettype none

module debug_tick_gen (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    output logic                tick,
    output debug_cfg_pkg::seq_t seq
);

    import debug_cfg_pkg::*;

    logic [TICK_CNT_WIDTH-1:0] div_cnt;
    logic                      div_last;

    // Last count of the divider
    assign div_last = (div_cnt == TICK_CNT_WIDTH'(TICK_DIV - 1));

    // Free-running modulo-TICK_DIV divider
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt <= '0;
        end else if (div_last) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Registered tick, first pulse TICK_DIV cycles after reset release
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tick <= 1'b0;
        end else begin
            tick <= div_last;
        end
    end

    // Signed down counter, wraps as two's complement
    // Software polls this to line up with the tick
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            seq <= '0;
        end else if (tick) begin
            seq <= seq - seq_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: dv/btn_debug_patterns.txt
// Columns (hex): op, address or channel, ticks or count, value, pslverr
// op 1 read, 2 write, 3 press, 4 glitch, 5 align (addr 1 checks first change), 0 end
1 00 0000 00000000 0
1 04 0000 00000000 0
1 08 0000 00000000 1
1 10 0000 00000000 0
1 14 0000 00000000 0
1 18 0000 00000000 0
1 1c 0000 00000000 0
1 20 0000 00000000 0
1 24 0000 00000000 0
5 01 0003 ffffffff 0
4 00 0003 00000000 0
4 01 0003 00000000 0
4 02 0003 00000000 0
1 04 0000 00000000 0
1 10 0000 00000000 0
1 14 0000 00000000 0
1 18 0000 00000000 0
1 1c 0000 00000000 0
1 20 0000 00000000 0
1 24 0000 00000000 0
5 00 0001 00000000 0
3 00 0002 00000000 0
1 10 0000 00000002 0
1 14 0000 00000001 0
1 1c 0000 00000000 0
1 24 0000 00000000 0
5 00 0001 00000000 0
3 01 0003 00000000 0
1 18 0000 00000003 0
1 1c 0000 00000001 0
1 10 0000 00000002 0
5 00 0001 00000000 0
3 02 0001 00000000 0
1 20 0000 00000001 0
1 24 0000 00000001 0
1 14 0000 00000001 0
5 00 0001 00000000 0
3 00 0001 00000000 0
1 10 0000 00000003 0
1 14 0000 00000002 0
1 18 0000 00000003 0
2 08 0000 00000002 0
1 18 0000 00000000 0
1 1c 0000 00000000 0
1 10 0000 00000003 0
1 24 0000 00000001 0
2 04 0000 ffffffff 1
2 10 0000 00000000 1
2 0c 0000 00000007 1
2 00 0000 00001234 1
1 0c 0000 00000000 1
1 40 0000 00000000 1
1 10 0000 00000003 0
1 14 0000 00000002 0
1 20 0000 00000001 0
1 04 0000 00000000 0
2 08 0000 00000001 0
1 10 0000 00000000 0
1 14 0000 00000000 0
1 20 0000 00000001 0
1 24 0000 00000001 0
0 00 0000 00000000 0

// File: dv/tb_btn_debug.sv
`default_nettype none

module tb_btn_debug;

    import debug_cfg_pkg::*;
    import debug_regs_pkg::*;

    localparam int MAX_OPS            = 128;
    localparam int FIELDS             = 5;
    localparam int RST_LIMIT          = 64;
    localparam int PREADY_LIMIT       = 16;
    localparam int ALIGN_POLL_LIMIT   = TICK_DIV;
    localparam int RELEASE_POLL_LIMIT = DEBOUNCE_CYCLES + 8;
    localparam logic [31:0] SEED      = 32'h949e_1f0f;

    // Pattern opcodes
    localparam logic [31:0] OP_END    = 32'd0;
    localparam logic [31:0] OP_READ   = 32'd1;
    localparam logic [31:0] OP_WRITE  = 32'd2;
    localparam logic [31:0] OP_PRESS  = 32'd3;
    localparam logic [31:0] OP_GLITCH = 32'd4;
    localparam logic [31:0] OP_ALIGN  = 32'd5;

    logic                      sys_clk;
    logic                      sys_rst_n;
    logic [CHAN_NUM-1:0]       btns;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic [31:0]               pat_mem [FIELDS*MAX_OPS];
    int                        n_checks;

    tb_clk_gen u_clk_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    // Bit 0 left, 1 right, 2 jump
    btn_debug_top u_dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .left_btn  (btns[0]),
        .right_btn (btns[1]),
        .jump_btn  (btns[2]),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    task automatic stop_with_error(input string what);
        $display("Error: %s", what);
        $display("Something failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sys_clk);
    endtask

    // Setup, then access until pready; response sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        @(negedge sys_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge sys_clk);
        penable = 1'b1;
        waits   = 0;
        while (pready !== 1'b1) begin
            if (waits == PREADY_LIMIT) stop_with_error("APB access cycle never saw pready");
            @(negedge sys_clk);
            waits++;
        end
        // Slave has no wait states
        check_value("APB wait states", waits, 32'd0);
        rdata = prdata;
        err   = pslverr;
        @(negedge sys_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    // Poll TICK_COUNT until it steps, a given number of times
    task automatic align_to_tick(input logic check_first, input int changes,
                                 input logic [31:0] first_val);
        logic [31:0] prev;
        logic [31:0] cur;
        logic        err;
        int          polls;
        apb_read(REG_TICK_COUNT, prev, err);
        check_value("TICK_COUNT pslverr", {31'h0, err}, 32'h0);
        for (int n = 0; n < changes; n++) begin
            polls = 0;
            cur   = prev;
            while (cur == prev) begin
                if (polls == ALIGN_POLL_LIMIT) stop_with_error("TICK_COUNT stopped changing");
                apb_read(REG_TICK_COUNT, cur, err);
                check_value("TICK_COUNT pslverr", {31'h0, err}, 32'h0);
                polls++;
            end
            // Down by one, upper half copies bit 15
            check_value("TICK_COUNT step", cur, prev - 32'd1);
            check_value("TICK_COUNT upper half", {16'h0, cur[31:16]},
                        {16'h0, {16{cur[15]}}});
            if (n == 0 && check_first) check_value("first TICK_COUNT change", cur, first_val);
            prev = cur;
        end
    endtask

    // Poll STATUS until the channel's level drops
    task automatic wait_release(input int chan);
        logic [31:0] rd;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(REG_STATUS, rd, err);
        while (rd[chan] !== 1'b0) begin
            if (polls == RELEASE_POLL_LIMIT) stop_with_error("button level never dropped");
            apb_read(REG_STATUS, rd, err);
            polls++;
        end
    endtask

    // Hold a button for ticks * TICK_DIV cycles, STATUS checked once settled
    task automatic press_button(input int chan, input int ticks);
        logic [31:0] rd;
        logic        err;
        btns[chan] = 1'b1;
        wait_cycles(DEBOUNCE_CYCLES + 3);
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS while held", rd, 32'h1 << chan);
        check_value("STATUS pslverr", {31'h0, err}, 32'h0);
        wait_cycles(ticks * TICK_DIV - DEBOUNCE_CYCLES - 6);
        btns[chan] = 1'b0;
        wait_release(chan);
        wait_cycles(int'($urandom % 4));
    endtask

    // Pulse shorter than the debounce window, then a quiet gap
    task automatic glitch_button(input int chan);
        int len;
        int gap;
        len = 1 + int'($urandom % (DEBOUNCE_CYCLES - 2));
        gap = DEBOUNCE_CYCLES + 4 + int'($urandom % 8);
        btns[chan] = 1'b1;
        wait_cycles(len);
        btns[chan] = 1'b0;
        wait_cycles(gap);
    endtask

    initial begin
        logic [31:0] op;
        logic [31:0] arg;
        logic [31:0] dur;
        logic [31:0] val;
        logic [31:0] exp_err;
        logic [31:0] rd;
        logic        rerr;
        logic        done;
        int          waits;
        btns     = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        n_checks = 0;
        done     = 1'b0;
        void'($urandom(SEED));
        $readmemh("dv/btn_debug_patterns.txt", pat_mem);
        waits = 0;
        while (sys_rst_n !== 1'b1) begin
            if (waits == RST_LIMIT) stop_with_error("reset was never released");
            @(negedge sys_clk);
            waits++;
        end
        for (int idx = 0; idx < MAX_OPS && !done; idx++) begin
            op      = pat_mem[FIELDS*idx];
            arg     = pat_mem[FIELDS*idx + 1];
            dur     = pat_mem[FIELDS*idx + 2];
            val     = pat_mem[FIELDS*idx + 3];
            exp_err = pat_mem[FIELDS*idx + 4];
            if ($isunknown(op)) stop_with_error("pattern file has no end entry");
            case (op)
                OP_READ: begin
                    apb_read(arg[7:0], rd, rerr);
                    check_value($sformatf("read data at %h", arg[7:0]), rd, val);
                    check_value($sformatf("read pslverr at %h", arg[7:0]),
                                {31'h0, rerr}, exp_err);
                end
                OP_WRITE: begin
                    apb_write(arg[7:0], val, rerr);
                    check_value($sformatf("write pslverr at %h", arg[7:0]),
                                {31'h0, rerr}, exp_err);
                end
                OP_PRESS:  press_button(int'(arg), int'(dur));
                OP_GLITCH: repeat (int'(dur)) glitch_button(int'(arg));
                OP_ALIGN:  align_to_tick(arg[0], int'(dur), val);
                OP_END:    done = 1'b1;
                default:   stop_with_error("unknown opcode in pattern file");
            endcase
        end
        if (n_checks == 0) begin
            stop_with_error("no checks ran");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic sys_clk,
    output logic sys_rst_n
);

    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 16;

    // Free-running clock, period 100
    initial begin
        sys_clk = 1'b0;
        forever #HALF_PERIOD sys_clk = ~sys_clk;
    end

    // Reset low for 16 cycles, released on a falling edge
    initial begin
        sys_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/debug_cfg_pkg.sv
common/debug_regs_pkg.sv
common/btn_stat_if.sv
design/debug_tick_gen.sv
btn_channel/btn_channel.sv
design/debug_apb_regs.sv
design/btn_debug_top.sv
dv/tb_clk_gen.sv
dv/tb_btn_debug.sv
